// File: verilog/mbus_pkg.sv
package mbus_pkg;

   // ####################################################################
   // Message widths
   // ####################################################################

   typedef logic [31:0] mbus_addr_t;
   typedef logic [31:0] mbus_data_t;
   typedef logic [63:0] mbus_payload_t;          // Address then data
   typedef logic [23:0] mbus_prefix_t;
   typedef logic [6:0]  mbus_cnt_t;

   localparam mbus_prefix_t NODE_PREFIX  = 24'haaaaab;
   localparam mbus_prefix_t BCAST_PREFIX = 24'h000000;
   localparam mbus_addr_t   INT_ADDR     = 32'h0000_00f0;  // Broadcast channel

   // ####################################################################
   // Frame timing
   // ####################################################################

   localparam int FRAME_BITS = 67;               // Start, payload, EOM, ACK
   localparam int BIT_CYCLES = 2;
   localparam int PH_W       = $clog2(BIT_CYCLES);

   typedef logic [PH_W-1:0] mbus_ph_t;

   localparam mbus_ph_t  PH_LAST      = mbus_ph_t'(BIT_CYCLES - 1);
   localparam mbus_ph_t  PH_HIGH      = mbus_ph_t'(BIT_CYCLES / 2);  // First clock-high phase
   localparam mbus_cnt_t ADDR_LAST    = mbus_cnt_t'($bits(mbus_addr_t) - 1);
   localparam mbus_cnt_t PAYLOAD_LAST = mbus_cnt_t'(FRAME_BITS - 3 - 1);

   typedef enum logic [2:0] {
      IDLE,
      ARB,
      START,
      PAYLOAD,
      EOM,
      ACK,
      DONE
   } bus_state_t;

endpackage

// File: verilog/mbus_shift_unit.sv
`timescale 1ns/1ps

module mbus_shift_unit
   import mbus_pkg::*;
(
   input  logic       clk_ext,
   input  logic       rst_n,
   input  logic       load,
   input  mbus_addr_t load_addr,
   input  mbus_data_t load_data,
   input  logic       shift_out,
   input  logic       shift_in,
   input  logic       din_bit,
   input  logic       clear,
   output logic       dout_bit,
   output mbus_cnt_t  bit_cnt,
   output mbus_addr_t rcv_addr,
   output mbus_data_t rcv_data,
   output logic       addr_match,
   output logic       addr_bcast
);

   mbus_payload_t tx_sr;
   mbus_payload_t rx_sr;
   mbus_prefix_t  new_prefix;

   // Prefix as it stands once the current bit is shifted in
   assign new_prefix = rx_sr[30:7];

   assign dout_bit = tx_sr[63];              // MSB first
   assign rcv_addr = rx_sr[63:32];
   assign rcv_data = rx_sr[31:0];

   // ####################################################################
   // Bit counter and address match
   // ####################################################################

   always_ff @(posedge clk_ext) begin
      if (!rst_n) begin
         bit_cnt    <= '0;
         addr_match <= 1'b0;
         addr_bcast <= 1'b0;
      end else if (clear) begin
         bit_cnt    <= '0;
         addr_match <= 1'b0;
         addr_bcast <= 1'b0;
      end else if (shift_out || shift_in) begin
         bit_cnt <= bit_cnt + 7'd1;
         if (shift_in && bit_cnt == ADDR_LAST) begin
            addr_match <= (new_prefix == NODE_PREFIX);
            addr_bcast <= (new_prefix == BCAST_PREFIX);
         end
      end
   end

   // ####################################################################
   // Shift registers
   // ####################################################################

   always_ff @(posedge clk_ext) begin
      if (load) begin
         tx_sr <= {load_addr, load_data};
      end else if (shift_out) begin
         tx_sr <= {tx_sr[62:0], 1'b0};
      end
   end

   always_ff @(posedge clk_ext) begin
      if (shift_in) begin
         rx_sr <= {rx_sr[62:0], din_bit};
      end
   end

endmodule

// File: verilog/mbus_bus_ctrl.sv
`timescale 1ns/1ps

module mbus_bus_ctrl
   import mbus_pkg::*;
(
   input  logic       clk_ext,
   input  logic       rst_n,
   input  logic       din,
   input  logic       clkin,
   input  mbus_addr_t tx_addr,
   input  mbus_data_t tx_data,
   input  logic       tx_req,
   input  logic       tx_priority,
   input  logic       tx_resp_ack,
   input  logic       rx_ack,
   input  logic       ext_int,
   output logic       dout_from_bus,
   output logic       clkout_from_bus,
   output logic       tx_ack,
   output logic       tx_succ,
   output logic       tx_fail,
   output mbus_addr_t rx_addr,
   output mbus_data_t rx_data,
   output logic       rx_req,
   output logic       rx_broadcast,
   output logic       clr_ext_int,
   output logic       clr_busy,
   output logic       bus_idle
);

   bus_state_t state;
   mbus_ph_t   ph_cnt;
   logic       bit_end;
   logic       frame_start;
   logic       tx_ready;
   logic       member_req;
   logic       member_win;
   logic       rx_mode;
   logic       int_mode;
   logic       tx_frame;
   logic       ack_in;
   logic       ack_out;
   logic       rx_accept;

   logic       su_load;
   logic       su_shift_out;
   logic       su_shift_in;
   logic       su_clear;
   mbus_addr_t su_load_addr;
   mbus_data_t su_load_data;
   logic       su_dout;
   mbus_cnt_t  bit_cnt;
   mbus_addr_t rcv_addr;
   mbus_data_t rcv_data;
   logic       addr_match;
   logic       addr_bcast;

   assign bit_end     = (ph_cnt == PH_LAST);
   assign frame_start = (state == START) && (ph_cnt == '0);
   assign tx_frame    = !rx_mode && !int_mode;
   assign tx_ready    = tx_req && !tx_ack && !tx_succ && !tx_fail && !tx_resp_ack;
   assign member_win  = (member_req || !din) && !ext_int && !(tx_ready && tx_priority);
   assign rx_accept   = (state == DONE) && rx_mode && ack_out;

   assign bus_idle    = (state == IDLE) || (state == ARB);
   assign clr_ext_int = frame_start && int_mode;
   assign clr_busy    = (state == DONE) && int_mode;

   // Bus clock low for the first half of each bit
   assign clkout_from_bus = (state == IDLE || state == DONE) ? 1'b1 : (ph_cnt >= PH_HIGH);

   // ####################################################################
   // Bit phase and frame FSM
   // ####################################################################

   always_ff @(posedge clk_ext) begin
      if (!rst_n) begin
         ph_cnt <= '0;
      end else if (state == IDLE || state == DONE || bit_end) begin
         ph_cnt <= '0;
      end else begin
         ph_cnt <= ph_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_ext) begin
      if (!rst_n) begin
         state      <= IDLE;
         member_req <= 1'b0;
         rx_mode    <= 1'b0;
         int_mode   <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (clkin && (!din || ext_int || tx_ready)) begin
                  state      <= ARB;
                  member_req <= !din;
               end
            end
            ARB: begin
               if (bit_end) begin
                  if (member_win) begin
                     state    <= START;
                     rx_mode  <= 1'b1;
                     int_mode <= 1'b0;
                  end else if (ext_int) begin      // Interrupt goes ahead of tx
                     state    <= START;
                     rx_mode  <= 1'b0;
                     int_mode <= 1'b1;
                  end else if (tx_ready) begin
                     state    <= START;
                     rx_mode  <= 1'b0;
                     int_mode <= 1'b0;
                  end else begin
                     state <= IDLE;
                  end
               end
            end
            START: begin
               if (bit_end) begin
                  state <= PAYLOAD;
               end
            end
            PAYLOAD: begin
               if (bit_end && bit_cnt == PAYLOAD_LAST) begin
                  state <= EOM;
               end
            end
            EOM: begin
               if (bit_end) begin
                  state <= ACK;
               end
            end
            ACK: begin
               if (bit_end) begin
                  state <= DONE;
               end
            end
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // ####################################################################
   // Local handshakes
   // ####################################################################

   always_ff @(posedge clk_ext) begin
      if (!rst_n) begin
         tx_ack       <= 1'b0;
         tx_succ      <= 1'b0;
         tx_fail      <= 1'b0;
         ack_in       <= 1'b0;
         ack_out      <= 1'b0;
         rx_req       <= 1'b0;
         rx_broadcast <= 1'b0;
      end else begin
         if (frame_start && tx_frame) begin
            tx_ack <= 1'b1;
         end else if (!tx_req) begin
            tx_ack <= 1'b0;
         end

         if (state == ACK && bit_end && !rx_mode) begin
            ack_in <= din;                      // Receiver's acknowledge
         end

         // Refuse while the last message is still with the layer
         if (state == EOM && bit_end && rx_mode) begin
            ack_out <= din && (addr_match || addr_bcast) && !rx_req && !rx_ack;
         end

         if (state == DONE && tx_frame) begin
            tx_succ <= ack_in;
            tx_fail <= !ack_in;
         end else if (tx_resp_ack) begin
            tx_succ <= 1'b0;
            tx_fail <= 1'b0;
         end

         if (rx_accept) begin
            rx_req       <= 1'b1;
            rx_broadcast <= addr_bcast;
         end else if (rx_ack) begin
            rx_req <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_ext) begin
      if (rx_accept) begin
         rx_addr <= rcv_addr;
         rx_data <= rcv_data;
      end
   end

   // ####################################################################
   // Data path
   // ####################################################################

   always_comb begin
      dout_from_bus = 1'b1;
      if (!rx_mode) begin
         if (state == START) begin
            dout_from_bus = 1'b0;
         end else if (state == PAYLOAD) begin
            dout_from_bus = su_dout;
         end
      end else if (state == ACK) begin
         dout_from_bus = ack_out;
      end
   end

   assign su_load      = frame_start && !rx_mode;
   assign su_shift_out = (state == PAYLOAD) && bit_end && !rx_mode;
   assign su_shift_in  = (state == PAYLOAD) && bit_end && rx_mode;
   assign su_clear     = (state == IDLE);
   assign su_load_addr = int_mode ? INT_ADDR : tx_addr;
   assign su_load_data = int_mode ? '0 : tx_data;

   mbus_shift_unit su0 (
      .clk_ext    (clk_ext),
      .rst_n      (rst_n),
      .load       (su_load),
      .load_addr  (su_load_addr),
      .load_data  (su_load_data),
      .shift_out  (su_shift_out),
      .shift_in   (su_shift_in),
      .din_bit    (din),
      .clear      (su_clear),
      .dout_bit   (su_dout),
      .bit_cnt    (bit_cnt),
      .rcv_addr   (rcv_addr),
      .rcv_data   (rcv_data),
      .addr_match (addr_match),
      .addr_bcast (addr_bcast)
   );

endmodule

// File: verilog/mbus_wire_ctrl.sv
`timescale 1ns/1ps

module mbus_wire_ctrl (
   input  logic clk_ext,
   input  logic rst_n,
   input  logic dout_from_bus,
   input  logic clkout_from_bus,
   input  logic bus_idle,
   input  logic ext_int_to_wire,
   output logic dout,
   output logic clkout
);

   logic wake_pull;

   // Pull the ring low to request the bus before the controller starts
   assign wake_pull = ext_int_to_wire && bus_idle && clkout_from_bus;

   always_ff @(posedge clk_ext) begin
      if (!rst_n) begin
         dout   <= 1'b1;                        // Idle ring level
         clkout <= 1'b1;
      end else begin
         clkout <= clkout_from_bus;
         dout   <= wake_pull ? 1'b0 : dout_from_bus;
      end
   end

endmodule

// File: verilog/mbus_int_ctrl.sv
`timescale 1ns/1ps

module mbus_int_ctrl (
   input  logic clk_ext,
   input  logic rst_n,
   input  logic irq,
   input  logic clr_ext_int,
   input  logic clr_busy,
   output logic ext_int_to_wire,
   output logic ext_int_to_bus
);

   logic irq_q;
   logic irq_rise;
   logic pending;
   logic busy;
   logic int_active;

   assign irq_rise   = irq && !irq_q;
   assign int_active = pending && !busy;

   assign ext_int_to_wire = int_active;
   assign ext_int_to_bus  = int_active;

   always_ff @(posedge clk_ext) begin
      if (!rst_n) begin
         irq_q   <= 1'b0;
         pending <= 1'b0;
         busy    <= 1'b0;
      end else begin
         irq_q <= irq;

         // A new edge wins over the clear from the bus
         pending <= irq_rise || (pending && !clr_ext_int);

         if (clr_ext_int) begin
            busy <= 1'b1;                       // Interrupt frame on the wire
         end else if (clr_busy) begin
            busy <= 1'b0;
         end
      end
   end

endmodule

// File: verilog/mbus_master_layer.sv
`timescale 1ns/1ps

module mbus_master_layer
   import mbus_pkg::*;
(
   input  logic       clk_ext,
   input  logic       rst_n,
   input  logic       clkin,
   input  logic       din,
   output logic       clkout,
   output logic       dout,
   input  mbus_addr_t tx_addr,
   input  mbus_data_t tx_data,
   input  logic       tx_req,
   input  logic       tx_priority,
   output logic       tx_ack,
   output mbus_addr_t rx_addr,
   output mbus_data_t rx_data,
   output logic       rx_req,
   input  logic       rx_ack,
   output logic       rx_broadcast,
   output logic       tx_fail,
   output logic       tx_succ,
   input  logic       tx_resp_ack,
   input  logic       irq
);

   logic w_m0wc0_clkout;
   logic w_m0wc0_dout;
   logic bus_idle;
   logic ext_int_to_wire;
   logic ext_int_to_bus;
   logic clr_ext_int;
   logic clr_busy;

   mbus_bus_ctrl m0 (
      .clk_ext         (clk_ext),
      .rst_n           (rst_n),
      .din             (din),
      .clkin           (clkin),
      .tx_addr         (tx_addr),
      .tx_data         (tx_data),
      .tx_req          (tx_req),
      .tx_priority     (tx_priority),
      .tx_resp_ack     (tx_resp_ack),
      .rx_ack          (rx_ack),
      .ext_int         (ext_int_to_bus),
      .dout_from_bus   (w_m0wc0_dout),
      .clkout_from_bus (w_m0wc0_clkout),
      .tx_ack          (tx_ack),
      .tx_succ         (tx_succ),
      .tx_fail         (tx_fail),
      .rx_addr         (rx_addr),
      .rx_data         (rx_data),
      .rx_req          (rx_req),
      .rx_broadcast    (rx_broadcast),
      .clr_ext_int     (clr_ext_int),
      .clr_busy        (clr_busy),
      .bus_idle        (bus_idle)
   );

   // Always-on pin stage
   mbus_wire_ctrl wc0 (
      .clk_ext         (clk_ext),
      .rst_n           (rst_n),
      .dout_from_bus   (w_m0wc0_dout),
      .clkout_from_bus (w_m0wc0_clkout),
      .bus_idle        (bus_idle),
      .ext_int_to_wire (ext_int_to_wire),
      .dout            (dout),
      .clkout          (clkout)
   );

   // Always-on interrupt tracking
   mbus_int_ctrl mic0 (
      .clk_ext         (clk_ext),
      .rst_n           (rst_n),
      .irq             (irq),
      .clr_ext_int     (clr_ext_int),
      .clr_busy        (clr_busy),
      .ext_int_to_wire (ext_int_to_wire),
      .ext_int_to_bus  (ext_int_to_bus)
   );

endmodule

// File: sim/mbus_member_model.sv
`timescale 1ns/1ps

module mbus_member_model
   import mbus_pkg::*;
(
   input  logic       clk,
   input  logic       clkout,
   input  logic       dout,
   input  logic       accept,
   input  logic       send_req,
   input  mbus_addr_t send_addr,
   input  mbus_data_t send_data,
   output logic       din,
   output logic       clkin,
   output int         rcv_cnt,
   output mbus_addr_t rcv_addr,
   output mbus_data_t rcv_data,
   output logic       rcv_eom,
   output int         sent_cnt,
   output logic       sent_ack
);

   logic [63:0] word;
   logic [63:0] sr;
   logic        prev_clk;
   logic        pending;
   logic        sending;
   int          rise;

   assign clkin = clkout;                     // Ring returns the master clock

   initial begin
      din      = 1'b1;
      rcv_cnt  = 0;
      sent_cnt = 0;
      rcv_eom  = 1'b0;
      sent_ack = 1'b0;
      prev_clk = 1'b1;
      pending  = 1'b0;
      sending  = 1'b0;
      rise     = -1;
   end

   // ####################################################################
   // Bit engine, one step per clkout rising edge
   // ####################################################################

   always @(negedge clk) begin
      if (send_req && !pending) begin
         pending = 1'b1;
         word    = {send_addr, send_data};
      end
      if (clkout === 1'b1 && prev_clk === 1'b1) begin
         rise    = -1;                        // Bus idle
         sending = 1'b0;
         din    <= !pending;                  // Request by pulling din low
      end else if (clkout === 1'b1 && prev_clk === 1'b0) begin
         rise = rise + 1;
         if (rise == 0) begin
            din <= !pending;                  // Start bit
         end else if (rise == 1) begin
            sending = pending && (dout === 1'b1);   // Master start bit means it won
            din    <= sending ? word[63] : 1'b1;
         end else if (sending) begin
            if (rise <= 64) begin
               din <= word[64 - rise];
            end else if (rise == 67) begin
               sent_ack <= dout;
               sent_cnt <= sent_cnt + 1;
               pending   = 1'b0;
            end else begin
               din <= 1'b1;                   // EOM, then leave ack to the master
            end
         end else begin
            if (rise <= 65) begin
               sr = {sr[62:0], dout};
            end else if (rise == 66) begin
               rcv_eom <= dout;
               din     <= accept;
            end else if (rise == 67) begin
               din      <= 1'b1;
               rcv_addr <= sr[63:32];
               rcv_data <= sr[31:0];
               rcv_cnt  <= rcv_cnt + 1;
            end
         end
      end
      prev_clk = clkout;
   end

endmodule

// File: sim/tb_mbus_master_layer.sv
`timescale 1ns/1ps

module tb_mbus_master_layer;
   import mbus_pkg::*;

   localparam int N_TRANS  = 28;
   localparam int LIMIT    = N_TRANS * (FRAME_BITS * BIT_CYCLES + 20);
   localparam int WAIT_MAX = 2 * (FRAME_BITS * BIT_CYCLES + 20);

   logic       clk_ext;
   logic       rst_n;
   logic       clkin;
   logic       din;
   logic       clkout;
   logic       dout;
   mbus_addr_t tx_addr;
   mbus_data_t tx_data;
   logic       tx_req;
   logic       tx_priority;
   logic       tx_ack;
   mbus_addr_t rx_addr;
   mbus_data_t rx_data;
   logic       rx_req;
   logic       rx_ack;
   logic       rx_broadcast;
   logic       tx_fail;
   logic       tx_succ;
   logic       tx_resp_ack;
   logic       irq;

   logic       accept;
   logic       send_req;
   mbus_addr_t send_addr;
   mbus_data_t send_data;
   int         rcv_cnt;
   mbus_addr_t rcv_addr;
   mbus_data_t rcv_data;
   logic       rcv_eom;
   int         sent_cnt;
   logic       sent_ack;

   integer     seed;
   int         val_errs;
   int         proto_errs;
   int         cycles;

   mbus_master_layer dut0 (.*);

   mbus_member_model mm0 (
      .clk (clk_ext), .clkout (clkout), .dout (dout), .accept (accept),
      .send_req (send_req), .send_addr (send_addr), .send_data (send_data),
      .din (din), .clkin (clkin), .rcv_cnt (rcv_cnt), .rcv_addr (rcv_addr),
      .rcv_data (rcv_data), .rcv_eom (rcv_eom), .sent_cnt (sent_cnt),
      .sent_ack (sent_ack)
   );

   always #2 clk_ext = ~clk_ext;

   always @(posedge clk_ext) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout after %0d cycles", LIMIT);
         $display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
         $display("Verification failed");
         $finish;
      end
   end

   // ####################################################################
   // Helpers
   // ####################################################################

   task automatic tick;
      @(posedge clk_ext);
      #1;
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         val_errs++;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic protocol_ok(input logic ok, input string what);
      assert (ok) else begin
         proto_errs++;
         $display("%s", what);
      end
   endtask

   task automatic await_rcv(input int old);
      int n;
      n = 0;
      while (rcv_cnt == old && n < WAIT_MAX) begin
         tick;
         n++;
      end
      protocol_ok(rcv_cnt != old, "member received no frame in time");
   endtask

   task automatic await_sent(input int old);
      int n;
      n = 0;
      while (sent_cnt == old && n < WAIT_MAX) begin
         tick;
         n++;
      end
      protocol_ok(sent_cnt != old, "member frame did not complete in time");
   endtask

   task automatic take_tx_ack;
      int n;
      n = 0;
      while (!tx_ack && n < WAIT_MAX) begin
         tick;
         n++;
      end
      protocol_ok(tx_ack, "tx_ack did not rise");
      tx_req = 1'b0;
   endtask

   task automatic close_tx(input logic acc);
      int n;
      int hold;
      n = 0;
      while (!tx_succ && !tx_fail && n < WAIT_MAX) begin
         tick;
         n++;
      end
      protocol_ok(tx_succ || tx_fail, "no transmit result after the frame");
      hold = $unsigned($random(seed)) % 4;
      repeat (hold) tick;                     // Result must hold until tx_resp_ack
      compare_value("tx_succ", tx_succ, acc);
      compare_value("tx_fail", tx_fail, !acc);
      tx_resp_ack = 1'b1;
      n = 0;
      while ((tx_succ || tx_fail) && n < 20) begin
         tick;
         n++;
      end
      protocol_ok(!tx_succ && !tx_fail, "transmit result did not fall after tx_resp_ack");
      tx_resp_ack = 1'b0;
      tick;
   endtask

   task automatic release_rx;
      int n;
      rx_ack = 1'b1;
      n = 0;
      while (rx_req && n < 20) begin
         tick;
         n++;
      end
      protocol_ok(!rx_req, "rx_req did not fall after rx_ack");
      rx_ack = 1'b0;
      tick;
   endtask

   task automatic close_rx(input mbus_addr_t a, input mbus_data_t d, input logic rel);
      int n;
      n = 0;
      while (!rx_req && n < 20) begin
         tick;
         n++;
      end
      protocol_ok(rx_req, "rx_req did not rise for an accepted message");
      compare_value("rx_addr", rx_addr, a);
      compare_value("rx_data", rx_data, d);
      compare_value("rx_broadcast", rx_broadcast, a[31:8] == BCAST_PREFIX);
      if (rel) begin
         release_rx;
      end
   endtask

   task automatic check_member_frame(input mbus_addr_t a, input mbus_data_t d);
      compare_value("member addr", rcv_addr, a);
      compare_value("member data", rcv_data, d);
      compare_value("member eom", rcv_eom, 1'b1);
   endtask

   // Reference rule for acknowledging a member message
   function automatic logic expect_accept(input mbus_addr_t a, input logic busy);
      return (a[31:8] == NODE_PREFIX || a[31:8] == BCAST_PREFIX) && !busy;
   endfunction

   task automatic pick_addr(output mbus_addr_t a);
      int           sel;
      mbus_prefix_t p;
      sel = $unsigned($random(seed)) % 3;
      p   = $random(seed);
      if (sel == 0) begin
         p = NODE_PREFIX;
      end else if (sel == 1) begin
         p = BCAST_PREFIX;
      end else if (p == NODE_PREFIX || p == BCAST_PREFIX) begin
         p = p ^ 24'h1;
      end
      a = {p, 8'($random(seed))};
   endtask

   // ####################################################################
   // Transactions
   // ####################################################################

   task automatic send_layer(input mbus_addr_t a, input mbus_data_t d, input logic acc);
      int r0;
      r0          = rcv_cnt;
      accept      = acc;
      tx_addr     = a;
      tx_data     = d;
      tx_priority = 1'b0;
      tx_req      = 1'b1;
      take_tx_ack;
      await_rcv(r0);
      check_member_frame(a, d);
      close_tx(acc);
   endtask

   task automatic send_member(input mbus_addr_t a, input mbus_data_t d,
                              input logic exp, input logic rel);
      int   s0;
      logic req_before;
      s0         = sent_cnt;
      req_before = rx_req;
      send_addr  = a;
      send_data  = d;
      send_req   = 1'b1;
      tick;
      send_req = 1'b0;
      await_sent(s0);
      compare_value("frame ack", sent_ack, exp);
      if (exp) begin
         close_rx(a, d, rel);
      end else begin
         repeat (4) tick;
         protocol_ok(rx_req == req_before, "rx_req changed for a refused message");
      end
   endtask

   task automatic race(input logic prio);
      mbus_addr_t ma;
      mbus_addr_t ta;
      mbus_data_t md;
      mbus_data_t td;
      int         s0;
      int         r0;
      int         n;
      logic       first_seen;
      logic       member_first;
      ma = {NODE_PREFIX, 8'($random(seed))};
      md = $random(seed);
      ta = $random(seed);
      td = $random(seed);
      s0 = sent_cnt;
      r0 = rcv_cnt;
      first_seen   = 1'b0;
      member_first = 1'b0;
      accept      = 1'b1;
      send_addr   = ma;
      send_data   = md;
      tx_addr     = ta;
      tx_data     = td;
      tx_priority = prio;
      tx_req      = 1'b1;
      send_req    = 1'b1;
      tick;
      send_req = 1'b0;
      n = 0;
      while ((sent_cnt == s0 || rcv_cnt == r0) && n < 2 * WAIT_MAX) begin
         if (tx_ack) tx_req = 1'b0;
         if (!first_seen && (sent_cnt != s0 || rcv_cnt != r0)) begin
            first_seen   = 1'b1;
            member_first = (sent_cnt != s0);
         end
         tick;
         n++;
      end
      protocol_ok(sent_cnt != s0 && rcv_cnt != r0, "arbitration frames did not both complete");
      compare_value("member_first", member_first, !prio);
      check_member_frame(ta, td);
      compare_value("frame ack", sent_ack, 1'b1);
      close_rx(ma, md, 1'b1);
      close_tx(1'b1);
   endtask

   task automatic irq_then_tx;
      mbus_addr_t ta;
      mbus_data_t td;
      int         r0;
      ta = $random(seed);
      td = $random(seed);
      r0 = rcv_cnt;
      accept      = 1'b1;
      tx_addr     = ta;
      tx_data     = td;
      tx_priority = 1'b0;
      tx_req      = 1'b1;
      irq         = 1'b1;
      tick;
      irq = 1'b0;
      await_rcv(r0);
      check_member_frame(INT_ADDR, '0);
      protocol_ok(!tx_ack, "layer message started ahead of the interrupt frame");
      r0 = rcv_cnt;
      take_tx_ack;
      await_rcv(r0);
      check_member_frame(ta, td);
      close_tx(1'b1);
      r0  = rcv_cnt;
      irq = 1'b1;                             // Second pulse after the first frame ended
      tick;
      irq = 1'b0;
      tick;
      compare_value("dout", dout, 1'b0);      // Wakeup pull-down on the idle ring
      await_rcv(r0);
      check_member_frame(INT_ADDR, '0);
      r0 = rcv_cnt;
      repeat (WAIT_MAX) tick;
      protocol_ok(rcv_cnt == r0, "extra frame after a single interrupt");
   endtask

   // ####################################################################
   // Test sequence
   // ####################################################################

   initial begin : main
      mbus_addr_t a;
      mbus_addr_t a1;
      mbus_data_t d;
      mbus_data_t d1;
      logic       acc;
      seed        = 41;
      val_errs    = 0;
      proto_errs  = 0;
      cycles      = 0;
      clk_ext     = 1'b0;
      rst_n       = 1'b0;
      tx_addr     = '0;
      tx_data     = '0;
      tx_req      = 1'b0;
      tx_priority = 1'b0;
      tx_resp_ack = 1'b0;
      rx_ack      = 1'b0;
      irq         = 1'b0;
      accept      = 1'b1;
      send_req    = 1'b0;
      send_addr   = '0;
      send_data   = '0;
      repeat (4) @(posedge clk_ext);
      #1;
      rst_n = 1'b1;

      compare_value("dout", dout, 1'b1);
      compare_value("clkout", clkout, 1'b1);
      compare_value("tx_ack", tx_ack, 1'b0);
      compare_value("tx_succ", tx_succ, 1'b0);
      compare_value("tx_fail", tx_fail, 1'b0);
      compare_value("rx_req", rx_req, 1'b0);

      repeat (6) begin
         a   = $random(seed);
         d   = $random(seed);
         acc = $random(seed) & 1;
         send_layer(a, d, acc);
      end

      repeat (8) begin
         pick_addr(a);
         d = $random(seed);
         send_member(a, d, expect_accept(a, rx_req), 1'b1);
      end

      // Back-pressure with the first message held
      a1 = {NODE_PREFIX, 8'($random(seed))};
      d1 = $random(seed);
      send_member(a1, d1, expect_accept(a1, rx_req), 1'b0);
      a = {NODE_PREFIX, 8'($random(seed))};
      d = $random(seed);
      send_member(a, d, expect_accept(a, rx_req), 1'b0);
      compare_value("rx_addr", rx_addr, a1);
      compare_value("rx_data", rx_data, d1);
      release_rx;

      race(1'b0);
      race(1'b1);
      irq_then_tx;

      $display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
      if (val_errs + proto_errs == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
verilog/mbus_pkg.sv
verilog/mbus_shift_unit.sv
verilog/mbus_bus_ctrl.sv
verilog/mbus_wire_ctrl.sv
verilog/mbus_int_ctrl.sv
verilog/mbus_master_layer.sv
sim/mbus_member_model.sv
sim/tb_mbus_master_layer.sv

// File: Bender.yml
package:
  name: mbus_master_layer

sources:
  - files:
      - verilog/mbus_pkg.sv
      - verilog/mbus_shift_unit.sv
      - verilog/mbus_bus_ctrl.sv
      - verilog/mbus_wire_ctrl.sv
      - verilog/mbus_int_ctrl.sv
      - verilog/mbus_master_layer.sv
  - target: simulation
    files:
      - sim/mbus_member_model.sv
      - sim/tb_mbus_master_layer.sv
